// File: all.f
design/lsu_pkg.sv
design/lsu_issue.sv
design/lsu_load_unit.sv
design/lsu_store_unit.sv
design/lsu_retire.sv
design/lsu_top.sv
testbench/tb_axi_mem.sv
testbench/tb_lsu_top.sv

// File: design/lsu_issue.sv
// load/store issue stage
`timescale 1ns/1ps

module lsu_issue #(
  parameter int pend_depth = lsu_pkg::default_depth
) (
  input  logic             clk,
  input  logic             rst,
  // request from the core
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  lsu_pkg::mem_op_e req_op_i,
  // routed request valids
  output logic             ld_req_valid_o,
  input  logic             ld_req_ready_i,
  output logic             st_req_valid_o,
  input  logic             st_req_ready_i,
  // completion pulses from retire
  input  logic             ld_cpl_done_i,
  input  logic             st_cpl_done_i
);
  import lsu_pkg::*;

  // staged, queued and retiring requests all fit below this
  localparam int cnt_max = 2 * pend_depth + 1;
  localparam int cnt_w = $clog2(cnt_max + 1);

  mem_op_e          op_q;
  logic [cnt_w-1:0] cnt_q;
  logic             en_q;
  logic             kind_ok;
  logic             room;
  logic             go;
  logic             accept;
  logic             retired;

  // a new kind may start only once the old one has drained
  assign kind_ok = (req_op_i == op_q) || (cnt_q == '0);
  assign room = (cnt_q != cnt_w'(cnt_max));
  assign go = en_q && kind_ok && room;

  assign ld_req_valid_o = req_valid_i && go && (req_op_i == op_load);
  assign st_req_valid_o = req_valid_i && go && (req_op_i == op_store);
  assign req_ready_o = go && ((req_op_i == op_load) ? ld_req_ready_i : st_req_ready_i);

  assign accept = req_valid_i && req_ready_o;
  // only the kind in flight can retire
  assign retired = (op_q == op_load) ? ld_cpl_done_i : st_cpl_done_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
      op_q <= op_load;
      cnt_q <= '0;
    end else begin
      en_q <= 1'b1;
      if (accept) begin
        op_q <= req_op_i;
      end
      case ({accept, retired})
        2'b10: cnt_q <= cnt_q + 1'b1;
        2'b01: cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// File: design/lsu_load_unit.sv
// read channel load engine
`timescale 1ns/1ps

module lsu_load_unit #(
  parameter int pend_depth = lsu_pkg::default_depth
) (
  input  logic                       clk,
  input  logic                       rst,
  // request from issue
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [lsu_pkg::addr_w-1:0] req_addr_i,
  input  lsu_pkg::mem_size_e         req_size_i,
  input  logic                       req_signed_i,
  input  logic [lsu_pkg::reg_w-1:0]  req_rd_i,
  // read address channel
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output logic [lsu_pkg::addr_w-1:0] ar_addr_o,
  // read data channel
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  logic [lsu_pkg::xlen-1:0]   r_data_i,
  input  logic [lsu_pkg::resp_w-1:0] r_resp_i,
  // completion to retire
  output logic                       ld_valid_o,
  input  logic                       ld_ready_i,
  output logic [lsu_pkg::reg_w-1:0]  ld_rd_o,
  output logic [lsu_pkg::xlen-1:0]   ld_data_o,
  output logic                       ld_err_o
);
  import lsu_pkg::*;

  localparam int ptr_w = (pend_depth > 1) ? $clog2(pend_depth) : 1;
  localparam int cnt_w = $clog2(pend_depth + 1);

  // address stage
  logic              ar_valid_q;
  logic [addr_w-1:0] addr_q;
  mem_size_e         size_q;
  logic              sgn_q;
  logic [reg_w-1:0]  rd_q;

  // pending queue, one entry per issued read
  logic [reg_w-1:0]  q_rd [pend_depth];
  mem_size_e         q_size [pend_depth];
  logic              q_sgn [pend_depth];
  logic [off_w-1:0]  q_off [pend_depth];
  logic [ptr_w-1:0]  wr_ptr_q;
  logic [ptr_w-1:0]  rd_ptr_q;
  logic [cnt_w-1:0]  cnt_q;
  logic [cnt_w:0]    occ;

  logic              ar_hs;
  logic              r_hs;
  logic              not_empty;
  logic [xlen-1:0]   beat;
  logic              sgn;

  assign ar_hs = ar_valid_q && ar_ready_i;
  assign r_hs = r_valid_i && r_ready_o;
  assign not_empty = (cnt_q != '0);
  assign occ = {1'b0, cnt_q} + {{cnt_w{1'b0}}, ar_valid_q};

  // staged read will push too, so leave space for it
  assign req_ready_o = (!ar_valid_q || ar_ready_i) && (occ < (cnt_w + 1)'(pend_depth));

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o = {addr_q[addr_w-1:off_w], {off_w{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      ar_valid_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      ar_valid_q <= 1'b1;
    end else if (ar_hs) begin
      ar_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      addr_q <= req_addr_i;
      size_q <= req_size_i;
      sgn_q <= req_signed_i;
      rd_q <= req_rd_i;
    end
    if (ar_hs) begin
      q_rd[wr_ptr_q] <= rd_q;
      q_size[wr_ptr_q] <= size_q;
      q_sgn[wr_ptr_q] <= sgn_q;
      q_off[wr_ptr_q] <= addr_q[off_w-1:0];
    end
  end

  // ====================================================================
  // queue pointers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q <= '0;
    end else begin
      if (ar_hs) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(pend_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (r_hs) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(pend_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({ar_hs, r_hs})
        2'b10: cnt_q <= cnt_q + 1'b1;
        2'b01: cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ====================================================================
  // data formatter
  // ====================================================================
  assign r_ready_o = not_empty && ld_ready_i;
  assign ld_valid_o = r_valid_i && not_empty;
  assign ld_rd_o = q_rd[rd_ptr_q];
  // error beats still carry their data
  assign ld_err_o = (r_resp_i != resp_okay);

  assign sgn = q_sgn[rd_ptr_q];
  assign beat = r_data_i >> {q_off[rd_ptr_q], 3'b000};

  always_comb begin
    case (q_size[rd_ptr_q])
      size_b: ld_data_o = {{(xlen - 8){sgn & beat[7]}}, beat[7:0]};
      size_h: ld_data_o = {{(xlen - 16){sgn & beat[15]}}, beat[15:0]};
      size_w: ld_data_o = {{(xlen - 32){sgn & beat[31]}}, beat[31:0]};
      default: ld_data_o = beat;
    endcase
  end

endmodule

// File: design/lsu_pkg.sv
// load/store unit shared definitions
package lsu_pkg;

  // ====================================================================
  // widths
  // ====================================================================
  // data path width
  localparam int xlen = 64;
  localparam int addr_w = 32;
  // one strobe bit per data byte
  localparam int strb_w = xlen / 8;
  // byte offset inside one beat
  localparam int off_w = $clog2(strb_w);
  localparam int reg_w = 5;

  // ====================================================================
  // response codes
  // ====================================================================
  localparam int resp_w = 2;
  // anything else counts as an error
  localparam logic [resp_w-1:0] resp_okay = 2'b00;

  // ====================================================================
  // queue sizing
  // ====================================================================
  localparam int default_depth = 4;

  // access size, 1/2/4/8 bytes
  typedef enum logic [1:0] {
    size_b = 2'd0,
    size_h = 2'd1,
    size_w = 2'd2,
    size_d = 2'd3
  } mem_size_e;

  // operation kind
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

endpackage

// File: design/lsu_retire.sv
// load/store completion retire stage
`timescale 1ns/1ps

module lsu_retire (
  input  logic                      clk,
  input  logic                      rst,
  // load completions
  input  logic                      ld_valid_i,
  output logic                      ld_ready_o,
  input  logic [lsu_pkg::reg_w-1:0] ld_rd_i,
  input  logic [lsu_pkg::xlen-1:0]  ld_data_i,
  input  logic                      ld_err_i,
  // store completions
  input  logic                      st_valid_i,
  output logic                      st_ready_o,
  input  logic                      st_err_i,
  // retire pulses back to issue
  output logic                      ld_cpl_done_o,
  output logic                      st_cpl_done_o,
  // completion stream to the core
  output logic                      cpl_valid_o,
  input  logic                      cpl_ready_i,
  output lsu_pkg::mem_op_e          cpl_op_o,
  output logic [lsu_pkg::reg_w-1:0] cpl_rd_o,
  output logic                      cpl_wen_o,
  output logic [lsu_pkg::xlen-1:0]  cpl_data_o,
  output logic                      cpl_err_o
);
  import lsu_pkg::*;

  logic             cpl_valid_q;
  mem_op_e          op_q;
  logic [reg_w-1:0] rd_q;
  logic             wen_q;
  logic [xlen-1:0]  data_q;
  logic             err_q;
  logic             free;
  logic             ld_take;
  logic             st_take;
  logic             cpl_hs;

  // register empty or draining this cycle
  assign free = !cpl_valid_q || cpl_ready_i;
  assign ld_ready_o = free;
  // loads win
  assign st_ready_o = free && !ld_valid_i;
  assign ld_take = ld_valid_i && ld_ready_o;
  assign st_take = st_valid_i && st_ready_o;

  assign cpl_hs = cpl_valid_q && cpl_ready_i;
  assign ld_cpl_done_o = cpl_hs && (op_q == op_load);
  assign st_cpl_done_o = cpl_hs && (op_q == op_store);

  always_ff @(posedge clk) begin
    if (rst) begin
      cpl_valid_q <= 1'b0;
    end else if (ld_take || st_take) begin
      cpl_valid_q <= 1'b1;
    end else if (cpl_hs) begin
      cpl_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_take) begin
      op_q <= op_load;
      rd_q <= ld_rd_i;
      wen_q <= (ld_rd_i != '0) && !ld_err_i;
      data_q <= ld_data_i;
      err_q <= ld_err_i;
    end else if (st_take) begin
      // stores write no register
      op_q <= op_store;
      rd_q <= '0;
      wen_q <= 1'b0;
      data_q <= '0;
      err_q <= st_err_i;
    end
  end

  assign cpl_valid_o = cpl_valid_q;
  assign cpl_op_o = op_q;
  assign cpl_rd_o = rd_q;
  assign cpl_wen_o = wen_q;
  assign cpl_data_o = data_q;
  assign cpl_err_o = err_q;

endmodule

// File: design/lsu_store_unit.sv
// write channel store engine
`timescale 1ns/1ps

module lsu_store_unit #(
  parameter int pend_depth = lsu_pkg::default_depth
) (
  input  logic                       clk,
  input  logic                       rst,
  // request from issue
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [lsu_pkg::addr_w-1:0] req_addr_i,
  input  logic [lsu_pkg::xlen-1:0]   req_wdata_i,
  input  lsu_pkg::mem_size_e         req_size_i,
  // write address and data channels
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  output logic [lsu_pkg::addr_w-1:0] aw_addr_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  output logic [lsu_pkg::xlen-1:0]   w_data_o,
  output logic [lsu_pkg::strb_w-1:0] w_strb_o,
  // write response channel
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  input  logic [lsu_pkg::resp_w-1:0] b_resp_i,
  // completion to retire
  output logic                       st_valid_o,
  input  logic                       st_ready_i,
  output logic                       st_err_o
);
  import lsu_pkg::*;

  localparam int cnt_w = $clog2(pend_depth + 1);

  // staged write
  logic              busy_q;
  logic              aw_sent_q;
  logic              w_sent_q;
  logic [addr_w-1:0] aw_addr_q;
  logic [xlen-1:0]   w_data_q;
  logic [strb_w-1:0] w_strb_q;

  // responses still due
  logic [cnt_w-1:0]  cnt_q;
  logic [cnt_w:0]    occ;

  logic [strb_w-1:0] size_mask;
  logic [off_w-1:0]  off;
  logic              aw_done;
  logic              w_done;
  logic              both_done;
  logic              b_hs;

  assign aw_valid_o = busy_q && !aw_sent_q;
  assign w_valid_o = busy_q && !w_sent_q;
  assign aw_addr_o = aw_addr_q;
  assign w_data_o = w_data_q;
  assign w_strb_o = w_strb_q;

  // either handshake may land first
  assign aw_done = aw_sent_q || (aw_valid_o && aw_ready_i);
  assign w_done = w_sent_q || (w_valid_o && w_ready_i);
  assign both_done = busy_q && aw_done && w_done;

  assign occ = {1'b0, cnt_q} + {{cnt_w{1'b0}}, busy_q};
  assign req_ready_o = (!busy_q || both_done) && (occ < (cnt_w + 1)'(pend_depth));

  // byte mask of the access size
  always_comb begin
    case (req_size_i)
      size_b: size_mask = strb_w'(8'h01);
      size_h: size_mask = strb_w'(8'h03);
      size_w: size_mask = strb_w'(8'h0f);
      default: size_mask = '1;
    endcase
  end

  assign off = req_addr_i[off_w-1:0];

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      aw_addr_q <= {req_addr_i[addr_w-1:off_w], {off_w{1'b0}}};
      w_data_q <= req_wdata_i << {off, 3'b000};
      w_strb_q <= size_mask << off;
    end
  end

  // ====================================================================
  // handshake tracking
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      aw_sent_q <= 1'b0;
      w_sent_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      busy_q <= 1'b1;
      aw_sent_q <= 1'b0;
      w_sent_q <= 1'b0;
    end else if (both_done) begin
      busy_q <= 1'b0;
      aw_sent_q <= 1'b0;
      w_sent_q <= 1'b0;
    end else begin
      aw_sent_q <= aw_done;
      w_sent_q <= w_done;
    end
  end

  // ====================================================================
  // response queue
  // ====================================================================
  assign b_ready_o = (cnt_q != '0) && st_ready_i;
  assign st_valid_o = b_valid_i && (cnt_q != '0);
  assign st_err_o = (b_resp_i != resp_okay);
  assign b_hs = b_valid_i && b_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else begin
      case ({both_done, b_hs})
        2'b10: cnt_q <= cnt_q + 1'b1;
        2'b01: cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// File: design/lsu_top.sv
// load/store memory stage top level
`timescale 1ns/1ps

module lsu_top #(
  parameter int pend_depth = lsu_pkg::default_depth
) (
  input  logic                       clk,
  input  logic                       rst,
  // request from the core
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  lsu_pkg::mem_op_e           req_op_i,
  input  logic [lsu_pkg::addr_w-1:0] req_addr_i,
  input  logic [lsu_pkg::xlen-1:0]   req_wdata_i,
  input  lsu_pkg::mem_size_e         req_size_i,
  input  logic                       req_signed_i,
  input  logic [lsu_pkg::reg_w-1:0]  req_rd_i,
  // completion to the core
  output logic                       cpl_valid_o,
  input  logic                       cpl_ready_i,
  output lsu_pkg::mem_op_e           cpl_op_o,
  output logic [lsu_pkg::reg_w-1:0]  cpl_rd_o,
  output logic                       cpl_wen_o,
  output logic [lsu_pkg::xlen-1:0]   cpl_data_o,
  output logic                       cpl_err_o,
  // read channels
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output logic [lsu_pkg::addr_w-1:0] ar_addr_o,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  input  logic [lsu_pkg::xlen-1:0]   r_data_i,
  input  logic [lsu_pkg::resp_w-1:0] r_resp_i,
  // write channels
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  output logic [lsu_pkg::addr_w-1:0] aw_addr_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  output logic [lsu_pkg::xlen-1:0]   w_data_o,
  output logic [lsu_pkg::strb_w-1:0] w_strb_o,
  input  logic                       b_valid_i,
  output logic                       b_ready_o,
  input  logic [lsu_pkg::resp_w-1:0] b_resp_i
);
  import lsu_pkg::*;

  logic             ld_req_valid;
  logic             ld_req_ready;
  logic             st_req_valid;
  logic             st_req_ready;
  logic             ld_cpl_done;
  logic             st_cpl_done;
  logic             ld_valid;
  logic             ld_ready;
  logic [reg_w-1:0] ld_rd;
  logic [xlen-1:0]  ld_data;
  logic             ld_err;
  logic             st_valid;
  logic             st_ready;
  logic             st_err;

  lsu_issue #(
    .pend_depth(pend_depth)
  ) lsu_issue_i (
    .clk(clk),
    .rst(rst),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_op_i(req_op_i),
    .ld_req_valid_o(ld_req_valid),
    .ld_req_ready_i(ld_req_ready),
    .st_req_valid_o(st_req_valid),
    .st_req_ready_i(st_req_ready),
    .ld_cpl_done_i(ld_cpl_done),
    .st_cpl_done_i(st_cpl_done)
  );

  lsu_load_unit #(
    .pend_depth(pend_depth)
  ) lsu_load_unit_i (
    .clk(clk),
    .rst(rst),
    .req_valid_i(ld_req_valid),
    .req_ready_o(ld_req_ready),
    .req_addr_i(req_addr_i),
    .req_size_i(req_size_i),
    .req_signed_i(req_signed_i),
    .req_rd_i(req_rd_i),
    .ar_valid_o(ar_valid_o),
    .ar_ready_i(ar_ready_i),
    .ar_addr_o(ar_addr_o),
    .r_valid_i(r_valid_i),
    .r_ready_o(r_ready_o),
    .r_data_i(r_data_i),
    .r_resp_i(r_resp_i),
    .ld_valid_o(ld_valid),
    .ld_ready_i(ld_ready),
    .ld_rd_o(ld_rd),
    .ld_data_o(ld_data),
    .ld_err_o(ld_err)
  );

  lsu_store_unit #(
    .pend_depth(pend_depth)
  ) lsu_store_unit_i (
    .clk(clk),
    .rst(rst),
    .req_valid_i(st_req_valid),
    .req_ready_o(st_req_ready),
    .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i),
    .req_size_i(req_size_i),
    .aw_valid_o(aw_valid_o),
    .aw_ready_i(aw_ready_i),
    .aw_addr_o(aw_addr_o),
    .w_valid_o(w_valid_o),
    .w_ready_i(w_ready_i),
    .w_data_o(w_data_o),
    .w_strb_o(w_strb_o),
    .b_valid_i(b_valid_i),
    .b_ready_o(b_ready_o),
    .b_resp_i(b_resp_i),
    .st_valid_o(st_valid),
    .st_ready_i(st_ready),
    .st_err_o(st_err)
  );

  lsu_retire lsu_retire_i (
    .clk(clk),
    .rst(rst),
    .ld_valid_i(ld_valid),
    .ld_ready_o(ld_ready),
    .ld_rd_i(ld_rd),
    .ld_data_i(ld_data),
    .ld_err_i(ld_err),
    .st_valid_i(st_valid),
    .st_ready_o(st_ready),
    .st_err_i(st_err),
    .ld_cpl_done_o(ld_cpl_done),
    .st_cpl_done_o(st_cpl_done),
    .cpl_valid_o(cpl_valid_o),
    .cpl_ready_i(cpl_ready_i),
    .cpl_op_o(cpl_op_o),
    .cpl_rd_o(cpl_rd_o),
    .cpl_wen_o(cpl_wen_o),
    .cpl_data_o(cpl_data_o),
    .cpl_err_o(cpl_err_o)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module tb_lsu_top \
  -f all.f \
  -Mdir obj_dir -o tb_lsu_top &&
./obj_dir/tb_lsu_top ||
{ echo "simulation returned a failing status"; exit 1; }

// File: testbench/tb_axi_mem.sv
// AXI-lite memory slave model
`timescale 1ns/1ps

module tb_axi_mem #(
  parameter int words = 256,
  parameter int err_base = 240
) (
  input  logic                       clk,
  // read channels
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  logic [lsu_pkg::addr_w-1:0] ar_addr_i,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output logic [lsu_pkg::xlen-1:0]   r_data_o,
  output logic [lsu_pkg::resp_w-1:0] r_resp_o,
  // write channels
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  logic [lsu_pkg::addr_w-1:0] aw_addr_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  logic [lsu_pkg::xlen-1:0]   w_data_i,
  input  logic [lsu_pkg::strb_w-1:0] w_strb_i,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output logic [lsu_pkg::resp_w-1:0] b_resp_o
);
  import lsu_pkg::*;

  localparam int idx_w = $clog2(words);
  localparam logic [resp_w-1:0] resp_slverr = 2'b10;

  logic [xlen-1:0]   mem [words];
  // accepted addresses and data still waiting
  logic [idx_w-1:0]  rd_q [$];
  logic [idx_w-1:0]  aw_q [$];
  logic [xlen-1:0]   wd_q [$];
  logic [strb_w-1:0] ws_q [$];
  logic [resp_w-1:0] b_q [$];
  logic              r_hs;
  logic              b_hs;

  function automatic logic [idx_w-1:0] word_of(input logic [addr_w-1:0] addr);
    return addr[off_w +: idx_w];
  endfunction

  // top doublewords answer with an error
  function automatic logic [resp_w-1:0] resp_of(input logic [idx_w-1:0] idx);
    return (int'(idx) >= err_base) ? resp_slverr : resp_okay;
  endfunction

  task automatic apply_write;
    logic [idx_w-1:0]  idx;
    logic [xlen-1:0]   data;
    logic [strb_w-1:0] strb;
    idx = aw_q.pop_front();
    data = wd_q.pop_front();
    strb = ws_q.pop_front();
    // failed writes leave memory alone
    if (resp_of(idx) == resp_okay) begin
      for (int j = 0; j < strb_w; j++) begin
        if (strb[j]) begin
          mem[idx][8 * j +: 8] = data[8 * j +: 8];
        end
      end
    end
    b_q.push_back(resp_of(idx));
  endtask

  initial begin
    for (int i = 0; i < words; i++) begin
      mem[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);
    end
    ar_ready_o = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o = 1'b0;
    r_valid_o = 1'b0;
    r_data_o = '0;
    r_resp_o = resp_okay;
    b_valid_o = 1'b0;
    b_resp_o = resp_okay;
    r_hs = 1'b0;
    b_hs = 1'b0;
    forever begin
      // all channel signals are settled by the falling edge
      @(negedge clk);
      r_hs = r_valid_o && r_ready_i;
      b_hs = b_valid_o && b_ready_i;
      if (ar_valid_i && ar_ready_o) begin
        rd_q.push_back(word_of(ar_addr_i));
      end
      if (aw_valid_i && aw_ready_o) begin
        aw_q.push_back(word_of(aw_addr_i));
      end
      if (w_valid_i && w_ready_o) begin
        wd_q.push_back(w_data_i);
        ws_q.push_back(w_strb_i);
      end
      while (aw_q.size() != 0 && wd_q.size() != 0) begin
        apply_write();
      end
      if (r_hs) begin
        rd_q.delete(0);
      end
      if (b_hs) begin
        b_q.delete(0);
      end
      @(posedge clk);
      #1;
      ar_ready_o = ($urandom_range(3) != 0);
      aw_ready_o = ($urandom_range(3) != 0);
      w_ready_o = ($urandom_range(3) != 0);
      // a raised beat holds until its handshake
      if (!r_valid_o || r_hs) begin
        r_valid_o = (rd_q.size() != 0) && ($urandom_range(3) != 0);
        if (r_valid_o) begin
          r_data_o = mem[rd_q[0]];
          r_resp_o = resp_of(rd_q[0]);
        end
      end
      if (!b_valid_o || b_hs) begin
        b_valid_o = (b_q.size() != 0) && ($urandom_range(3) != 0);
        if (b_valid_o) begin
          b_resp_o = b_q[0];
        end
      end
    end
  end

endmodule

// File: testbench/tb_lsu_top.sv
// load/store unit testbench
`timescale 1ns/1ps

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int pend_depth = 4;
  localparam int n_reqs = 400;
  localparam int timeout = 1000;
  localparam int words = 256;
  localparam int err_base = 240;

  typedef struct packed {
    mem_op_e          op;
    logic [reg_w-1:0] rd;
    logic             wen;
    logic [xlen-1:0]  data;
    logic             err;
  } cpl_t;

  logic              clk;
  logic              rst;
  logic              req_valid;
  logic              req_ready;
  mem_op_e           req_op;
  logic [addr_w-1:0] req_addr;
  logic [xlen-1:0]   req_wdata;
  mem_size_e         req_size;
  logic              req_signed;
  logic [reg_w-1:0]  req_rd;
  logic              cpl_valid;
  logic              cpl_ready;
  mem_op_e           cpl_op;
  logic [reg_w-1:0]  cpl_rd;
  logic              cpl_wen;
  logic [xlen-1:0]   cpl_data;
  logic              cpl_err;
  logic              ar_valid;
  logic              ar_ready;
  logic [addr_w-1:0] ar_addr;
  logic              r_valid;
  logic              r_ready;
  logic [xlen-1:0]   r_data;
  logic [resp_w-1:0] r_resp;
  logic              aw_valid;
  logic              aw_ready;
  logic [addr_w-1:0] aw_addr;
  logic              w_valid;
  logic              w_ready;
  logic [xlen-1:0]   w_data;
  logic [strb_w-1:0] w_strb;
  logic              b_valid;
  logic              b_ready;
  logic [resp_w-1:0] b_resp;

  // reference model state
  logic [xlen-1:0]   mirror [words];
  cpl_t              exp_q [$];
  logic [addr_w-1:0] aw_want;
  int                accepted;
  int                completed;
  int                idle;
  logic              saw_full;

  lsu_top #(
    .pend_depth(pend_depth)
  ) lsu_top_i (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_op_i(req_op),
    .req_addr_i(req_addr), .req_wdata_i(req_wdata), .req_size_i(req_size),
    .req_signed_i(req_signed), .req_rd_i(req_rd),
    .cpl_valid_o(cpl_valid), .cpl_ready_i(cpl_ready), .cpl_op_o(cpl_op),
    .cpl_rd_o(cpl_rd), .cpl_wen_o(cpl_wen), .cpl_data_o(cpl_data), .cpl_err_o(cpl_err),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data), .r_resp_i(r_resp),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_data_o(w_data), .w_strb_o(w_strb),
    .b_valid_i(b_valid), .b_ready_o(b_ready), .b_resp_i(b_resp)
  );

  tb_axi_mem #(
    .words(words),
    .err_base(err_base)
  ) mem_i (
    .clk(clk),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_resp_o(r_resp),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
    .b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================================================================
  // checking helpers
  // ====================================================================
  task automatic stop_run;
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] want);
    assert (got == want) else begin
      $display("error %0t %s got %h expected %h", $time, name, got, want);
      stop_run();
    end
  endtask

  // pick the lane, then extend from its top bit
  function automatic logic [xlen-1:0] load_value(input logic [xlen-1:0] word,
      input logic [off_w-1:0] off, input mem_size_e size, input logic sgn);
    int              nbits;
    logic [xlen-1:0] lane;
    logic [xlen-1:0] keep;
    nbits = 8 << int'(size);
    lane = word >> (8 * int'(off));
    keep = (nbits == xlen) ? '1 : ((64'd1 << nbits) - 64'd1);
    if (sgn && lane[nbits - 1]) begin
      return lane | ~keep;
    end
    return lane & keep;
  endfunction

  task automatic record_request;
    int   idx;
    int   off;
    cpl_t want;
    idx = int'(req_addr[off_w +: 8]);
    off = int'(req_addr[off_w-1:0]);
    want.op = req_op;
    want.err = (idx >= err_base);
    if (req_op == op_load) begin
      want.rd = req_rd;
      want.data = load_value(mirror[idx], req_addr[off_w-1:0], req_size, req_signed);
      want.wen = (req_rd != '0) && !want.err;
    end else begin
      want.rd = '0;
      want.data = '0;
      want.wen = 1'b0;
      // write address goes out on a doubleword boundary
      aw_want = req_addr & ~addr_w'(strb_w - 1);
      if (!want.err) begin
        for (int j = 0; j < (1 << int'(req_size)); j++) begin
          mirror[idx][8 * (off + j) +: 8] = req_wdata[8 * j +: 8];
        end
      end
    end
    exp_q.push_back(want);
    accepted++;
  endtask

  task automatic check_completion;
    cpl_t want;
    assert (exp_q.size() != 0) else begin
      $display("completion arrived with no request outstanding");
      stop_run();
    end
    want = exp_q.pop_front();
    check_value("cpl_op_o", 64'(cpl_op), 64'(want.op));
    check_value("cpl_rd_o", 64'(cpl_rd), 64'(want.rd));
    check_value("cpl_err_o", 64'(cpl_err), 64'(want.err));
    check_value("cpl_wen_o", 64'(cpl_wen), 64'(want.wen));
    check_value("cpl_data_o", cpl_data, want.data);
    completed++;
  endtask

  // ====================================================================
  // monitor, sampled on the falling edge
  // ====================================================================
  initial begin
    accepted = 0;
    completed = 0;
    idle = 0;
    saw_full = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        // unit queue plus the retire register is the most in flight
        if (accepted - completed > pend_depth) begin
          saw_full = 1'b1;
          assert (!req_ready && accepted - completed == pend_depth + 1) else begin
            $display("req_ready_o stays high with %0d requests outstanding",
                     accepted - completed);
            stop_run();
          end
        end
        if (aw_valid) begin
          check_value("aw_addr_o", 64'(aw_addr), 64'(aw_want));
        end
        if (cpl_valid && cpl_ready) begin
          check_completion();
          idle = 0;
        end else if (exp_q.size() != 0) begin
          idle++;
          assert (idle < timeout) else begin
            $display("no completion arrived for %0d cycles", timeout);
            stop_run();
          end
        end
        if (req_valid && req_ready) begin
          record_request();
        end
      end
    end
  end

  // completion back-pressure, with long stalls now and then
  initial begin
    int stall;
    stall = 0;
    cpl_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (stall > 0) begin
        stall--;
        cpl_ready = 1'b0;
      end else if ($urandom_range(47) == 0) begin
        stall = 20 + $urandom_range(60);
        cpl_ready = 1'b0;
      end else begin
        cpl_ready = ($urandom_range(3) != 0);
      end
    end
  end

  task automatic send_request(input mem_op_e op, input logic [7:0] idx,
                              input mem_size_e size);
    int              waited;
    logic [off_w-1:0] off;
    // natural alignment clears the low offset bits
    off = off_w'($urandom_range(7)) & ~off_w'((1 << int'(size)) - 1);
    req_valid = 1'b1;
    req_op = op;
    req_addr = {21'd0, idx, off};
    req_wdata = {$urandom, $urandom};
    req_size = size;
    req_signed = 1'($urandom_range(1));
    req_rd = reg_w'($urandom_range(31));
    waited = 0;
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      assert (waited < timeout) else begin
        $display("request was not accepted within %0d cycles", timeout);
        stop_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    int        seed;
    int        waited;
    mem_op_e   op;
    logic [7:0] idx;
    seed = $urandom(29);
    rst = 1'b1;
    req_valid = 1'b0;
    req_op = op_load;
    req_addr = '0;
    req_wdata = '0;
    req_size = size_b;
    req_signed = 1'b0;
    req_rd = '0;
    for (int i = 0; i < words; i++) begin
      mirror[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);
    end
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_value("req_ready_o", 64'(req_ready), 64'd0);
    check_value("ar_valid_o", 64'(ar_valid), 64'd0);
    check_value("aw_valid_o", 64'(aw_valid), 64'd0);
    check_value("w_valid_o", 64'(w_valid), 64'd0);
    check_value("r_ready_o", 64'(r_ready), 64'd0);
    check_value("b_ready_o", 64'(b_ready), 64'd0);
    check_value("cpl_valid_o", 64'(cpl_valid), 64'd0);
    @(posedge clk);
    #1;
    rst = 1'b0;
    waited = 0;
    while (!req_ready) begin
      waited++;
      assert (waited < timeout) else begin
        $display("req_ready_o never rose after reset");
        stop_run();
      end
      @(posedge clk);
      #1;
    end
    op = op_load;
    for (int n = 0; n < n_reqs; n++) begin
      // runs of one kind let the queues fill
      if ($urandom_range(3) == 0) begin
        op = (op == op_load) ? op_store : op_load;
      end
      if ($urandom_range(7) == 0) begin
        idx = 8'(err_base + $urandom_range(15));
      end else begin
        idx = 8'($urandom_range(23));
      end
      send_request(op, idx, mem_size_e'($urandom_range(3)));
      if ($urandom_range(7) == 0) begin
        @(posedge clk);
        #1;
      end
    end
    waited = 0;
    while (completed < n_reqs) begin
      waited++;
      assert (waited < timeout) else begin
        $display("only %0d of %0d completions arrived", completed, n_reqs);
        stop_run();
      end
      @(posedge clk);
    end
    // stray completions would show up here
    repeat (20) @(posedge clk);
    assert (saw_full) else begin
      $display("request port never filled the pending queue");
      stop_run();
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
